//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := clb_tile_tb
FILELIST  := clb_tile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- clb_tile.f
common/fabric_pkg.sv
common/channel_if.sv
verilog/config_shift_reg.sv
slice/logic_slice.sv
routing/connection_block.sv
routing/switch_box.sv
verilog/clb_tile.sv
verification/clb_tile_tb.sv

//--- common/channel_if.sv
`timescale 1ns/1ps

// Routing channel on one side of a block.
// Directions are named as the blk side sees them.
interface channel_if;
  import fabric_pkg::*;

  // Tracks arriving at the blk side.
  logic [WS-1:0] single_in;
  logic [WD-1:0] double_in;

  // Tracks leaving the blk side.
  logic [WS-1:0] single_out;
  logic [WD-1:0] double_out;

  // View of the block that owns this side.
  modport blk (
    input  single_in,
    input  double_in,
    output single_out,
    output double_out
  );

  // View from across the channel.
  modport far (
    output single_in,
    output double_in,
    input  single_out,
    input  double_out
  );

endinterface

//--- common/fabric_pkg.sv
package fabric_pkg;

  // Routing channel widths, counted per side of the tile.
  // Single tracks span one tile.
  localparam int WS = 4;
  // Double tracks span two tiles.
  localparam int WD = 4;
  // Global lines in each direction.
  localparam int WG = 3;

  // All tracks on one side.
  // Index order is singles first, then doubles.
  localparam int WT = WS + WD;

  // Number of sides around the switch box.
  localparam int NUM_SIDES = 4;

  // Logic slice geometry.
  localparam int NUM_LUTS = 4;
  localparam int LUT_K = 4;
  // One truth table holds 2**K entries.
  localparam int LUT_BITS = 1 << LUT_K;
  // Every LUT input is a separate slice pin.
  localparam int SLICE_PINS = NUM_LUTS * LUT_K;

  // Connection block pin muxes.
  // Sources are the side0 tracks, then the globals.
  localparam int PIN_SRC = WT + WG;
  // A select of PIN_SRC or more drives the pin low.
  localparam int PIN_SEL_W = 4;
  // Each of the two blocks feeds half of the slice pins.
  localparam int CB_PINS = SLICE_PINS / 2;

  // Switch box source select for one outgoing track.
  // The side is named relative to the outgoing track's own side.
  typedef enum logic [1:0] {
    SRC_NONE = 2'd0,
    SRC_CW   = 2'd1,
    SRC_OPP  = 2'd2,
    SRC_CCW  = 2'd3
  } sb_src_e;

  localparam int SB_SEL_W = $bits(sb_src_e);

  // Configuration segment widths along the chain.
  // Slice holds all truth tables back to back.
  localparam int SLICE_CFG_W = NUM_LUTS * LUT_BITS;
  // Pin selects first, then one injection bit per track.
  localparam int CB_CFG_W = CB_PINS * PIN_SEL_W + WT;
  // One select per outgoing track on every side.
  localparam int SB_CFG_W = NUM_SIDES * WT * SB_SEL_W;

  // Whole chain through slice, cb_north, sb and cb_east.
  localparam int CHAIN_LEN = SLICE_CFG_W + 2 * CB_CFG_W + SB_CFG_W;

endpackage

//--- routing/connection_block.sv
`timescale 1ns/1ps

// Connection block between a routing channel and the slice.
// Tracks pass from side0 to side1 and back.
// Slice outputs can replace tracks heading toward side1.
module connection_block (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cen,
  input  logic                           set,
  input  logic                           shift_in,
  output logic                           shift_out,
  channel_if.far                         side0,
  channel_if.far                         side1,
  input  logic [fabric_pkg::WG-1:0]       global_in,
  input  logic [fabric_pkg::NUM_LUTS-1:0] lut_out,
  output logic [fabric_pkg::CB_PINS-1:0]  pins
);
  import fabric_pkg::*;

  logic [CB_CFG_W-1:0] cfg;
  // Injection enables, one per side1 outgoing track.
  logic [WT-1:0]       inject;
  // Tracks as seen at each side, singles in the low bits.
  logic [WT-1:0]       s0_in;
  logic [WT-1:0]       s1_in;
  logic [WT-1:0]       s1_out;
  // Everything a pin can pick from.
  logic [PIN_SRC-1:0]  pin_src;

  config_shift_reg #(
    .WIDTH(CB_CFG_W)
  ) u_cfg (
    .clk      (clk),
    .rst_n    (rst_n),
    .cen      (cen),
    .set      (set),
    .shift_in (shift_in),
    .shift_out(shift_out),
    .cfg      (cfg)
  );

  assign inject  = cfg[CB_PINS*PIN_SEL_W +: WT];
  assign s0_in   = {side0.double_out, side0.single_out};
  assign s1_in   = {side1.double_out, side1.single_out};
  // Tracks first, globals above them.
  assign pin_src = {global_in, s0_in};

  // Pin muxes.
  // Out of range selects leave the pin low.
  always_comb begin
    logic [PIN_SEL_W-1:0] sel;
    sel = '0;
    for (int p = 0; p < CB_PINS; p++) begin
      sel     = cfg[p*PIN_SEL_W +: PIN_SEL_W];
      pins[p] = (sel < PIN_SRC) ? pin_src[sel] : 1'b0;
    end
  end

  // Track i can carry LUT i mod NUM_LUTS instead of its own signal.
  always_comb begin
    for (int i = 0; i < WT; i++) begin
      s1_out[i] = inject[i] ? lut_out[i % NUM_LUTS] : s0_in[i];
    end
  end

  assign side1.single_in = s1_out[WS-1:0];
  assign side1.double_in = s1_out[WT-1:WS];
  // Reverse direction is a plain pass.
  assign side0.single_in = s1_in[WS-1:0];
  assign side0.double_in = s1_in[WT-1:WS];

endmodule

//--- routing/switch_box.sv
`timescale 1ns/1ps

// Disjoint switch box.
// Each outgoing track copies the same index from one other side.
module switch_box (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   cen,
  input  logic   set,
  input  logic   shift_in,
  output logic   shift_out,
  channel_if.blk north,
  channel_if.blk east,
  channel_if.blk south,
  channel_if.blk west
);
  import fabric_pkg::*;

  logic [SB_CFG_W-1:0] cfg;
  // Sides indexed north, east, south, west.
  logic [WT-1:0] trk_in  [NUM_SIDES];
  logic [WT-1:0] trk_out [NUM_SIDES];

  config_shift_reg #(
    .WIDTH(SB_CFG_W)
  ) u_cfg (
    .clk      (clk),
    .rst_n    (rst_n),
    .cen      (cen),
    .set      (set),
    .shift_in (shift_in),
    .shift_out(shift_out),
    .cfg      (cfg)
  );

  assign trk_in[0] = {north.double_in, north.single_in};
  assign trk_in[1] = {east.double_in,  east.single_in};
  assign trk_in[2] = {south.double_in, south.single_in};
  assign trk_in[3] = {west.double_in,  west.single_in};

  // Clockwise from side s is s+1, counter clockwise is s+3.
  always_comb begin
    sb_src_e sel;
    sel = SRC_NONE;
    for (int s = 0; s < NUM_SIDES; s++) begin
      for (int i = 0; i < WT; i++) begin
        sel = sb_src_e'(cfg[(s*WT+i)*SB_SEL_W +: SB_SEL_W]);
        case (sel)
          SRC_CW:  trk_out[s][i] = trk_in[(s+1)%NUM_SIDES][i];
          SRC_OPP: trk_out[s][i] = trk_in[(s+2)%NUM_SIDES][i];
          SRC_CCW: trk_out[s][i] = trk_in[(s+3)%NUM_SIDES][i];
          default: trk_out[s][i] = 1'b0;
        endcase
      end
    end
  end

  assign north.single_out = trk_out[0][WS-1:0];
  assign north.double_out = trk_out[0][WT-1:WS];
  assign east.single_out  = trk_out[1][WS-1:0];
  assign east.double_out  = trk_out[1][WT-1:WS];
  assign south.single_out = trk_out[2][WS-1:0];
  assign south.double_out = trk_out[2][WT-1:WS];
  assign west.single_out  = trk_out[3][WS-1:0];
  assign west.double_out  = trk_out[3][WT-1:WS];

  // Once loaded, every select must be a defined source.
  // An unknown select would spread X over the whole channel.
  sel_known_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (set && cen) |=> !$isunknown(cfg)
  );

endmodule

//--- slice/logic_slice.sv
`timescale 1ns/1ps

// Logic slice with NUM_LUTS four-input LUTs.
// Each LUT feeds a flip-flop, so every output is registered.
module logic_slice (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             cen,
  input  logic                             set,
  input  logic                             shift_in,
  output logic                             shift_out,
  input  logic [fabric_pkg::SLICE_PINS-1:0] pins,
  output logic [fabric_pkg::NUM_LUTS-1:0]   lut_out
);
  import fabric_pkg::*;

  // All truth tables, LUT 0 in the lowest bits.
  logic [SLICE_CFG_W-1:0] cfg;
  // LUT results before the flip-flops.
  logic [NUM_LUTS-1:0] lut_d;

  config_shift_reg #(
    .WIDTH(SLICE_CFG_W)
  ) u_cfg (
    .clk      (clk),
    .rst_n    (rst_n),
    .cen      (cen),
    .set      (set),
    .shift_in (shift_in),
    .shift_out(shift_out),
    .cfg      (cfg)
  );

  // Table lookup for each LUT.
  // Pin 4n is the least significant address bit of LUT n.
  always_comb begin
    logic [LUT_BITS-1:0] table_bits;
    logic [LUT_K-1:0]    addr;
    table_bits = '0;
    addr       = '0;
    for (int n = 0; n < NUM_LUTS; n++) begin
      table_bits = cfg[n*LUT_BITS +: LUT_BITS];
      addr       = pins[n*LUT_K +: LUT_K];
      lut_d[n]   = table_bits[addr];
    end
  end

  // Output flip-flops.
  // They break every route that would loop back through the slice.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lut_out <= '0;
    end else if (cen) begin
      lut_out <= lut_d;
    end
  end

  // Results are frozen while the fabric clock enable is low.
  // Routing downstream relies on this during a stalled load.
  lut_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !cen |=> $stable(lut_out)
  );

endmodule

//--- verification/clb_tile_tb.sv
`timescale 1ns/1ps

module clb_tile_tb;
  import fabric_pkg::*;

  localparam int CLK_NS = 8;
  localparam int SEED = 88284;
  // Chain segment offsets.
  // cb_east sits next to the serial output.
  localparam int CBE_OFS = 0;
  localparam int SB_OFS = CB_CFG_W;
  localparam int CBN_OFS = CB_CFG_W + SB_CFG_W;
  localparam int SLICE_OFS = 2 * CB_CFG_W + SB_CFG_W;
  // Injection bits sit above the pin selects in a cb segment.
  localparam int INJ_OFS = CB_PINS * PIN_SEL_W;
  localparam int NUM_LOADS = 20;
  localparam int WATCHDOG_NS = NUM_LOADS * 300 * CLK_NS + 10000;

  logic clk;
  logic rst_n;
  logic cen;
  logic shift_in;
  logic set_in;
  logic shift_out;
  logic set_out;
  logic [WS-1:0] north_single_in, east_single_in, south_single_in, west_single_in;
  logic [WD-1:0] north_double_in, east_double_in, south_double_in, west_double_in;
  logic [WS-1:0] north_single_out, east_single_out, south_single_out, west_single_out;
  logic [WD-1:0] north_double_out, east_double_out, south_double_out, west_double_out;
  logic [WG-1:0] global_vertical;
  logic [WG-1:0] global_horizontal;

  // Reference state of the tile.
  logic [CHAIN_LEN-1:0] m_shadow;
  logic [CHAIN_LEN-1:0] m_active;
  logic [NUM_LUTS-1:0]  m_lut;
  // LUT results that the next cen edge will capture.
  logic [NUM_LUTS-1:0]  m_lut_d;
  // Expected track outputs in north, east, south, west order.
  logic [WT-1:0]        exp_out [NUM_SIDES];
  int                   err_count;

  clb_tile dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .cen                (cen),
    .shift_in_from_north(shift_in),
    .set_in_from_north  (set_in),
    .shift_out_to_south (shift_out),
    .set_out_to_south   (set_out),
    .north_single_in    (north_single_in),
    .north_double_in    (north_double_in),
    .north_single_out   (north_single_out),
    .north_double_out   (north_double_out),
    .east_single_in     (east_single_in),
    .east_double_in     (east_double_in),
    .east_single_out    (east_single_out),
    .east_double_out    (east_double_out),
    .south_single_in    (south_single_in),
    .south_double_in    (south_double_in),
    .south_single_out   (south_single_out),
    .south_double_out   (south_double_out),
    .west_single_in     (west_single_in),
    .west_double_in     (west_double_in),
    .west_single_out    (west_single_out),
    .west_double_out    (west_double_out),
    .global_vertical    (global_vertical),
    .global_horizontal  (global_horizontal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // Pin source order is tracks first, then globals.
  // Selects past the globals read zero.
  function automatic logic pick_pin_source(input int sel, input logic [WT-1:0] trk,
                                           input logic [WG-1:0] glb);
    if (sel < WT) begin
      return trk[sel];
    end
    if (sel < PIN_SRC) begin
      return glb[sel - WT];
    end
    return 1'b0;
  endfunction

  // Combinational part of the tile model.
  task automatic evaluate_model();
    logic [WT-1:0]         tin [NUM_SIDES];
    logic [WT-1:0]         sb_out [NUM_SIDES];
    logic [WT-1:0]         west_in;
    logic [SLICE_PINS-1:0] pins;
    logic [LUT_K-1:0]      addr;
    int                    sel;
    tin[0] = {north_double_in, north_single_in};
    tin[1] = {east_double_in, east_single_in};
    // cb_east hands the south input straight back to the sb.
    tin[2] = {south_double_in, south_single_in};
    west_in = {west_double_in, west_single_in};
    // cb_north feeds the sb west side, with optional injection.
    for (int i = 0; i < WT; i++) begin
      tin[3][i] = m_active[CBN_OFS + INJ_OFS + i] ? m_lut[i % NUM_LUTS] : west_in[i];
    end
    // Select value counts sides clockwise from the track's own side.
    for (int s = 0; s < NUM_SIDES; s++) begin
      for (int i = 0; i < WT; i++) begin
        sel = int'(m_active[SB_OFS + (s * WT + i) * 2 +: 2]);
        sb_out[s][i] = (sel == 0) ? 1'b0 : tin[(s + sel) % NUM_SIDES][i];
      end
    end
    exp_out[0] = sb_out[0];
    exp_out[1] = sb_out[1];
    exp_out[3] = sb_out[3];
    for (int i = 0; i < WT; i++) begin
      exp_out[2][i] = m_active[CBE_OFS + INJ_OFS + i] ? m_lut[i % NUM_LUTS] : sb_out[2][i];
    end
    for (int p = 0; p < CB_PINS; p++) begin
      sel = int'(m_active[CBN_OFS + p * PIN_SEL_W +: PIN_SEL_W]);
      pins[p] = pick_pin_source(sel, west_in, global_horizontal);
      sel = int'(m_active[CBE_OFS + p * PIN_SEL_W +: PIN_SEL_W]);
      pins[CB_PINS + p] = pick_pin_source(sel, sb_out[2], global_vertical);
    end
    for (int n = 0; n < NUM_LUTS; n++) begin
      addr = pins[n * LUT_K +: LUT_K];
      m_lut_d[n] = m_active[SLICE_OFS + n * LUT_BITS + int'(addr)];
    end
  endtask

  // Clock edge of the model.
  // Active loads the pre-edge shadow.
  task automatic clock_model(input logic c, input logic s, input logic si);
    if (c) begin
      m_lut = m_lut_d;
      if (s) begin
        m_active = m_shadow;
      end
      m_shadow = {si, m_shadow[CHAIN_LEN-1:1]};
    end
  endtask

  task automatic drive_random_tracks();
    logic [31:0] ra;
    logic [31:0] rb;
    ra = $urandom();
    rb = $urandom();
    north_single_in   = ra[0 * WT +: WS];
    north_double_in   = ra[0 * WT + WS +: WD];
    east_single_in    = ra[1 * WT +: WS];
    east_double_in    = ra[1 * WT + WS +: WD];
    south_single_in   = ra[2 * WT +: WS];
    south_double_in   = ra[2 * WT + WS +: WD];
    west_single_in    = ra[3 * WT +: WS];
    west_double_in    = ra[3 * WT + WS +: WD];
    global_horizontal = rb[0 +: WG];
    global_vertical   = rb[WG +: WG];
  endtask

  task automatic compare_outputs();
    evaluate_model();
    check_equal(32'({north_double_out, north_single_out}), 32'(exp_out[0]), "north tracks");
    check_equal(32'({east_double_out, east_single_out}), 32'(exp_out[1]), "east tracks");
    check_equal(32'({south_double_out, south_single_out}), 32'(exp_out[2]), "south tracks");
    check_equal(32'({west_double_out, west_single_out}), 32'(exp_out[3]), "west tracks");
    check_equal(32'(shift_out), 32'(m_shadow[0]), "chain output");
    check_equal(32'(set_out), 32'(set_in), "set passthrough");
  endtask

  // One cycle with inputs driven on the falling edge.
  // Outputs are checked before the next rise.
  task automatic run_cycle(input logic c, input logic s, input logic si);
    @(negedge clk);
    cen      = c;
    set_in   = s;
    shift_in = si;
    drive_random_tracks();
    #1;
    compare_outputs();
    clock_model(c, s, si);
  endtask

  task automatic run_traffic(input int cycles);
    logic [31:0] rb;
    for (int k = 0; k < cycles; k++) begin
      rb = $urandom();
      run_cycle(1'b1, 1'b0, rb[0]);
    end
  endtask

  // Full shift of a random word, then a set strobe.
  task automatic load_config(input bit force_inject);
    logic [255:0]         raw;
    logic [CHAIN_LEN-1:0] word;
    logic [31:0]          rb;
    for (int k = 0; k < 8; k++) begin
      raw[k * 32 +: 32] = $urandom();
    end
    word = raw[CHAIN_LEN-1:0];
    if (force_inject) begin
      word[CBN_OFS + INJ_OFS +: WT] = '1;
      word[CBE_OFS + INJ_OFS +: WT] = '1;
    end
    // Bit 0 goes in first so it ends at the far end.
    for (int k = 0; k < CHAIN_LEN; k++) begin
      run_cycle(1'b1, 1'b0, word[k]);
    end
    rb = $urandom();
    run_cycle(1'b1, 1'b1, rb[0]);
  endtask

  // Each bit must reappear exactly CHAIN_LEN shifts later.
  task automatic check_stream();
    logic [255:0]         raw;
    logic [CHAIN_LEN-1:0] bits;
    for (int k = 0; k < 8; k++) begin
      raw[k * 32 +: 32] = $urandom();
    end
    bits = raw[CHAIN_LEN-1:0];
    for (int k = 0; k < CHAIN_LEN; k++) begin
      run_cycle(1'b1, 1'b0, bits[k]);
    end
    for (int k = 0; k < CHAIN_LEN; k++) begin
      run_cycle(1'b1, 1'b0, 1'b0);
      check_equal(32'(shift_out), 32'(bits[k]), "delayed stream bit");
    end
  endtask

  // Random cen spans.
  // Set only strobes while cen is low.
  task automatic check_cen_hold(input int cycles);
    int          left;
    logic        c;
    logic [31:0] rb;
    left = 0;
    c = 1'b1;
    for (int k = 0; k < cycles; k++) begin
      if (left == 0) begin
        c = ~c;
        left = int'($urandom_range(6, 1));
      end
      left--;
      rb = $urandom();
      run_cycle(c, rb[0] & ~c, rb[1]);
    end
  endtask

  initial begin
    err_count = 0;
    void'($urandom(SEED));
    rst_n = 1'b0;
    cen = 1'b0;
    set_in = 1'b0;
    shift_in = 1'b0;
    north_single_in = '0;
    north_double_in = '0;
    east_single_in = '0;
    east_double_in = '0;
    south_single_in = '0;
    south_double_in = '0;
    west_single_in = '0;
    west_double_in = '0;
    global_vertical = '0;
    global_horizontal = '0;
    m_shadow = '0;
    m_active = '0;
    m_lut = '0;
    m_lut_d = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Zero configuration with live traffic.
    for (int k = 0; k < 20; k++) begin
      run_cycle(1'b1, 1'b0, 1'b0);
    end
    check_stream();
    load_config(1'b0);
    run_traffic(40);
    load_config(1'b1);
    run_traffic(40);
    check_cen_hold(120);
    for (int k = 0; k < NUM_LOADS; k++) begin
      load_config(k[0]);
      run_traffic(12);
    end

    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- verilog/clb_tile.sv
`timescale 1ns/1ps

// One island-style logic tile.
// Chain order is slice, cb_north, sb, cb_east.
module clb_tile (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cen,
  input  logic                     shift_in_from_north,
  input  logic                     set_in_from_north,
  output logic                     shift_out_to_south,
  output logic                     set_out_to_south,
  input  logic [fabric_pkg::WS-1:0] north_single_in,
  input  logic [fabric_pkg::WD-1:0] north_double_in,
  output logic [fabric_pkg::WS-1:0] north_single_out,
  output logic [fabric_pkg::WD-1:0] north_double_out,
  input  logic [fabric_pkg::WS-1:0] east_single_in,
  input  logic [fabric_pkg::WD-1:0] east_double_in,
  output logic [fabric_pkg::WS-1:0] east_single_out,
  output logic [fabric_pkg::WD-1:0] east_double_out,
  input  logic [fabric_pkg::WS-1:0] south_single_in,
  input  logic [fabric_pkg::WD-1:0] south_double_in,
  output logic [fabric_pkg::WS-1:0] south_single_out,
  output logic [fabric_pkg::WD-1:0] south_double_out,
  input  logic [fabric_pkg::WS-1:0] west_single_in,
  input  logic [fabric_pkg::WD-1:0] west_double_in,
  output logic [fabric_pkg::WS-1:0] west_single_out,
  output logic [fabric_pkg::WD-1:0] west_double_out,
  input  logic [fabric_pkg::WG-1:0] global_vertical,
  input  logic [fabric_pkg::WG-1:0] global_horizontal
);
  import fabric_pkg::*;

  // Serial links between chain segments.
  logic slice_so, cb_north_so, sb_so;
  logic [SLICE_PINS-1:0] slice_pins;
  logic [NUM_LUTS-1:0]   lut_out;

  channel_if ch_north ();
  channel_if ch_east ();
  channel_if ch_south ();
  channel_if ch_west ();
  // Internal channels between sb and the connection blocks.
  channel_if sb_west ();
  channel_if sb_south ();

  // Switch box owns north and east.
  assign ch_north.single_in = north_single_in;
  assign ch_north.double_in = north_double_in;
  assign north_single_out   = ch_north.single_out;
  assign north_double_out   = ch_north.double_out;
  assign ch_east.single_in  = east_single_in;
  assign ch_east.double_in  = east_double_in;
  assign east_single_out    = ch_east.single_out;
  assign east_double_out    = ch_east.double_out;

  // West and south face the connection blocks from the far side.
  assign ch_west.single_out  = west_single_in;
  assign ch_west.double_out  = west_double_in;
  assign west_single_out     = ch_west.single_in;
  assign west_double_out     = ch_west.double_in;
  assign ch_south.single_out = south_single_in;
  assign ch_south.double_out = south_double_in;
  assign south_single_out    = ch_south.single_in;
  assign south_double_out    = ch_south.double_in;

  // Set goes to the next tile untouched so the column loads together.
  assign set_out_to_south = set_in_from_north;

  logic_slice u_slice (
    .clk      (clk),
    .rst_n    (rst_n),
    .cen      (cen),
    .set      (set_in_from_north),
    .shift_in (shift_in_from_north),
    .shift_out(slice_so),
    .pins     (slice_pins),
    .lut_out  (lut_out)
  );

  connection_block cb_north (
    .clk      (clk),
    .rst_n    (rst_n),
    .cen      (cen),
    .set      (set_in_from_north),
    .shift_in (slice_so),
    .shift_out(cb_north_so),
    .side0    (ch_west),
    .side1    (sb_west),
    .global_in(global_horizontal),
    .lut_out  (lut_out),
    .pins     (slice_pins[CB_PINS-1:0])
  );

  switch_box sb (
    .clk      (clk),
    .rst_n    (rst_n),
    .cen      (cen),
    .set      (set_in_from_north),
    .shift_in (cb_north_so),
    .shift_out(sb_so),
    .north    (ch_north),
    .east     (ch_east),
    .south    (sb_south),
    .west     (sb_west)
  );

  connection_block cb_east (
    .clk      (clk),
    .rst_n    (rst_n),
    .cen      (cen),
    .set      (set_in_from_north),
    .shift_in (sb_so),
    .shift_out(shift_out_to_south),
    .side0    (sb_south),
    .side1    (ch_south),
    .global_in(global_vertical),
    .lut_out  (lut_out),
    .pins     (slice_pins[SLICE_PINS-1:CB_PINS])
  );

endmodule

//--- verilog/config_shift_reg.sv
`timescale 1ns/1ps

// One segment of the serial configuration chain.
// The shadow shifts while cen is high.
// The active copy loads from the shadow on set.
module config_shift_reg #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cen,
  input  logic             set,
  input  logic             shift_in,
  output logic             shift_out,
  output logic [WIDTH-1:0] cfg
);

  // Bits being loaded.
  logic [WIDTH-1:0] shadow;
  // Bits the block acts on.
  logic [WIDTH-1:0] active;

  // New bits enter at the top and walk down.
  // Bit 0 is the next one handed to the following block.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shadow <= '0;
    end else if (cen) begin
      shadow <= {shift_in, shadow[WIDTH-1:1]};
    end
  end

  // Active takes the shadow as it stood before this edge.
  // So a set on the last shift edge misses that final bit.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= '0;
    end else if (cen && set) begin
      active <= shadow;
    end
  end

  assign shift_out = shadow[0];
  assign cfg       = active;

  // The strobe is shared by every tile in the column.
  // An unknown here would corrupt all of them at once.
  set_known_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(set)
  );

endmodule
